//--- Makefile
SIM := obj_dir/dma_sim

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module dma_tb -f sources.f

$(SIM): sources.f *.sv
	verilator --binary --timing --assert -Wno-fatal --top-module dma_tb \
		-f sources.f -o dma_sim

sim: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then echo "simulation gave no result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

//--- bus_arbiter.sv
`default_nettype none

module bus_arbiter (
    input  logic clock,
    input  logic n_reset,
    input  logic request,
    input  logic other_request,
    output logic grant,
    output logic other_grant
    );

    // set when the other master won the last contest
    logic last_other;

    always_ff @(posedge clock) begin
        if (!n_reset) begin
            grant       <= 1'b0;
            other_grant <= 1'b0;
            last_other  <= 1'b0;
        end else if (grant && request) begin
            // owner keeps the bus
            grant       <= 1'b1;
            other_grant <= 1'b0;
        end else if (other_grant && other_request) begin
            grant       <= 1'b0;
            other_grant <= 1'b1;
        end else if (request && (!other_request || last_other)) begin
            // free bus, alternate on conflict
            grant       <= 1'b1;
            other_grant <= 1'b0;
            last_other  <= 1'b0;
        end else if (other_request) begin
            grant       <= 1'b0;
            other_grant <= 1'b1;
            last_other  <= 1'b1;
        end else begin
            grant       <= 1'b0;
            other_grant <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- bus_memory.sv
`default_nettype none

module bus_memory
    import dma_pkg::*;
    #(
    parameter int unsigned           mem_words    = def_mem_words,
    parameter logic [data_width-1:0] mem_fill_key = def_mem_fill_key
    ) (
    input  logic      clock,
    input  logic      n_reset,
    dma_bus_if.target bus,
    input  logic      stall
    );

    localparam int idx_width = $clog2(mem_words);

    logic [data_width-1:0]  mem [mem_words];
    logic [idx_width-1:0]   idx;
    logic [burst_width-1:0] rd_cnt;
    logic                   rd_active;
    logic                   wr_active;
    logic                   err_end;

    // write beats are held off by stall
    assign bus.busy = wr_active && stall;

    always_ff @(posedge clock) begin
        if (!n_reset) begin
            rd_active               <= 1'b0;
            wr_active               <= 1'b0;
            err_end                 <= 1'b0;
            bus.tgt_data_valid      <= 1'b0;
            bus.tgt_end_transaction <= 1'b0;
            bus.bus_error           <= 1'b0;
            // known pattern for read checks
            for (int i = 0; i < int'(mem_words); i++) begin
                mem[i] <= data_width'(i) ^ mem_fill_key;
            end
        end else begin
            bus.tgt_data_valid      <= 1'b0;
            bus.bus_error           <= 1'b0;
            err_end                 <= 1'b0;
            // failed read closes one cycle after the error
            bus.tgt_end_transaction <= err_end;
            if (bus.begin_transaction) begin
                // address view on the first beat
                idx    <= bus.address_data.addr.word_index[idx_width-1:0];
                rd_cnt <= bus.burst_size;
                if (bus.address_data.addr.word_index >= (addr_width-2)'(mem_words)) begin
                    bus.bus_error <= 1'b1;
                    err_end       <= bus.read_n_write;
                    rd_active     <= 1'b0;
                    wr_active     <= 1'b0;
                end else begin
                    rd_active <= bus.read_n_write;
                    wr_active <= !bus.read_n_write;
                end
            end else if (rd_active && !stall) begin
                // one read beat, end marked on the last
                bus.tgt_data_valid        <= 1'b1;
                bus.tgt_address_data.data <= mem[idx];
                idx                       <= idx + 1'b1;
                rd_cnt                    <= rd_cnt - 1'b1;
                if (rd_cnt == burst_width'(1)) begin
                    bus.tgt_end_transaction <= 1'b1;
                    rd_active               <= 1'b0;
                end
            end else if (wr_active) begin
                // data view on write beats
                if (bus.data_valid && !stall) begin
                    mem[idx] <= bus.address_data.data;
                    idx      <= idx + 1'b1;
                end
                if (bus.end_transaction) begin
                    wr_active <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dma_bus_if.sv
`default_nettype none

interface dma_bus_if
    import dma_pkg::*;
    ();

    // resolved bus, driven by the direction mux at the top
    bus_word_t address_data;
    logic      data_valid;
    logic      end_transaction;

    // master side
    bus_word_t              mst_address_data;
    logic [3:0]             byte_enable;
    logic [burst_width-1:0] burst_size;
    logic                   read_n_write;
    logic                   begin_transaction;
    logic                   mst_data_valid;
    logic                   mst_end_transaction;

    // target side
    bus_word_t tgt_address_data;
    logic      tgt_data_valid;
    logic      tgt_end_transaction;
    logic      busy;
    logic      bus_error;

    modport master (
        output mst_address_data, byte_enable, burst_size, read_n_write,
        output begin_transaction, mst_data_valid, mst_end_transaction,
        input  address_data, data_valid, end_transaction, busy, bus_error
    );

    modport target (
        output tgt_address_data, tgt_data_valid, tgt_end_transaction, busy, bus_error,
        input  address_data, data_valid, end_transaction,
        input  burst_size, read_n_write, begin_transaction
    );

endinterface

`default_nettype wire

//--- dma_checker.sv
`default_nettype none

module dma_checker
    import dma_pkg::*;
    (
    input logic                  clock,
    input logic                  n_reset,
    input logic                  dma_busy,
    input logic                  dma_error,
    input logic                  grant,
    input logic                  other_grant,
    input logic [data_width-1:0] ip_read_data
    );

    timeunit 1ns;
    timeprecision 1ps;

    int value_errors = 0;
    int other_errors = 0;

    // one buffer word as the ip port shows it
    task automatic compare_word(input string name, input int index,
                                input logic [data_width-1:0] expected);
        if (ip_read_data !== expected) begin
            value_errors++;
            $display("FAIL %s word %0d expected %08h actual %08h",
                     name, index, expected, ip_read_data);
        end
    endtask

    // error flag at the end of a transfer
    task automatic compare_flag(input string name, input logic expected);
        if (dma_error !== expected) begin
            value_errors++;
            $display("FAIL %s dma_error expected %b actual %b", name, expected, dma_error);
        end
    endtask

    task automatic report_problem(input string text);
        other_errors++;
        $display("ERROR %s", text);
    endtask

    // bus ownership and reset state, sampled away from the edges
    always @(negedge clock) begin
        if (n_reset && grant && other_grant) begin
            report_problem($sformatf("both masters granted the bus at %0t", $time));
        end
        if (!n_reset && (dma_busy || dma_error)) begin
            report_problem($sformatf("engine not idle during reset at %0t", $time));
        end
    end

endmodule

`default_nettype wire

//--- dma_engine.sv
`default_nettype none

module dma_engine
    import dma_pkg::*;
    #(
    parameter logic [addr_width-1:0] base_address = 32'h0
    ) (
    input  logic                      clock,
    input  logic                      n_reset,
    input  logic                      launch_write,
    input  logic                      launch_read,
    input  logic [3:0]                byte_enable,
    input  logic [addr_width-1:0]     address,
    input  logic [burst_width-1:0]    burst_size,
    input  logic [burst_width-1:0]    block_size,
    output logic                      dma_busy,
    output logic                      dma_error,
    output logic [buf_addr_width-1:0] buf_address,
    output logic [data_width-1:0]     buf_write_data,
    output logic                      buf_write_enable,
    input  logic [data_width-1:0]     buf_read_data,
    dma_bus_if.master                 bus,
    output logic                      request,
    input  logic                      grant
    );

    dma_state_t state;

    // transfer setup and running counters
    logic [burst_width-1:0]    burst_q;
    logic [burst_width-1:0]    remaining;
    logic [burst_width-1:0]    burst_len;
    logic [burst_width-1:0]    beats;
    logic [addr_width-1:0]     run_addr;
    logic [buf_addr_width-1:0] ptr;

    // registered read path
    logic [data_width-1:0] rd_data_q;
    logic                  rd_valid_q;

    logic launch;
    logic load;

    assign launch = launch_write || launch_read;

    // next burst is the smaller of remainder and burst size
    assign burst_len = (remaining < burst_q) ? remaining : burst_q;

    assign dma_busy = (state != idle);
    assign request  = (state == request_bus);

    // take the next buffer word into the out register
    always_comb begin
        load = 1'b0;
        if (!bus.read_n_write) begin
            if (state == set_up) begin
                load = 1'b1;
            end else if (state == write && bus.mst_data_valid && !bus.busy && beats != '0) begin
                load = 1'b1;
            end
        end
    end

    // writes look one word ahead so read data is ready for the next load
    assign buf_address      = bus.read_n_write ? ptr : ptr + buf_addr_width'(load);
    assign buf_write_data   = rd_data_q;
    assign buf_write_enable = rd_valid_q;

    // control state and bus strobes
    always_ff @(posedge clock) begin
        if (!n_reset) begin
            state                   <= idle;
            dma_error               <= 1'b0;
            bus.begin_transaction   <= 1'b0;
            bus.mst_data_valid      <= 1'b0;
            bus.mst_end_transaction <= 1'b0;
            rd_valid_q              <= 1'b0;
        end else begin
            bus.begin_transaction   <= 1'b0;
            bus.mst_end_transaction <= 1'b0;
            // only beats of our own read count
            rd_valid_q              <= bus.data_valid && (state == read);
            case (state)
                idle: begin
                    if (launch) begin
                        state     <= init;
                        dma_error <= 1'b0;
                    end
                end
                init: begin
                    state <= request_bus;
                end
                request_bus: begin
                    if (grant) begin
                        state                 <= set_up;
                        bus.begin_transaction <= 1'b1;
                    end
                end
                set_up: begin
                    if (bus.read_n_write) begin
                        state <= read;
                    end else begin
                        state              <= write;
                        bus.mst_data_valid <= 1'b1;
                    end
                end
                read: begin
                    if (bus.bus_error) begin
                        state     <= wait_end;
                        dma_error <= 1'b1;
                    end else if (bus.end_transaction) begin
                        // last word lands in the buffer during the next cycle
                        state <= (remaining == '0) ? idle : request_bus;
                    end
                end
                wait_end: begin
                    if (bus.end_transaction) begin
                        state <= idle;
                    end
                end
                write: begin
                    if (bus.bus_error) begin
                        state                   <= end_error;
                        dma_error               <= 1'b1;
                        bus.mst_data_valid      <= 1'b0;
                        bus.mst_end_transaction <= 1'b1;
                    end else if (bus.mst_data_valid && !bus.busy && beats == '0) begin
                        state                   <= end_write;
                        bus.mst_data_valid      <= 1'b0;
                        bus.mst_end_transaction <= 1'b1;
                    end
                end
                end_write: begin
                    state <= (remaining == '0) ? idle : request_bus;
                end
                end_error: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // setup, counters and bus payload
    always_ff @(posedge clock) begin
        rd_data_q <= bus.address_data.data;
        if (state == idle && launch) begin
            burst_q          <= burst_size;
            remaining        <= block_size;
            run_addr         <= {address[addr_width-1:2], 2'b00} + base_address;
            bus.byte_enable  <= byte_enable;
            bus.read_n_write <= launch_read;
        end
        if (state == request_bus && grant) begin
            // address phase of the next burst
            bus.mst_address_data.addr.word_index  <= run_addr[addr_width-1:2];
            bus.mst_address_data.addr.byte_offset <= 2'b00;
            bus.burst_size <= burst_len;
            beats          <= burst_len - 1'b1;
            remaining      <= remaining - burst_len;
            run_addr       <= run_addr + addr_width'({burst_len, 2'b00});
        end else if (load) begin
            bus.mst_address_data.data <= buf_read_data;
            if (state == write) begin
                beats <= beats - 1'b1;
            end
        end
        // buffer pointer
        if (state == init) begin
            ptr <= '0;
        end else if (bus.read_n_write) begin
            ptr <= ptr + buf_addr_width'(buf_write_enable);
        end else begin
            ptr <= buf_address;
        end
    end

endmodule

`default_nettype wire

//--- dma_pkg.sv
`default_nettype none

package dma_pkg;

    // bus and buffer widths
    localparam int addr_width     = 32;
    localparam int data_width     = 32;
    localparam int buf_addr_width = 9;
    localparam int burst_width    = 8;

    // memory target defaults, overridden from the top level
    localparam int unsigned           def_mem_words    = 1024;
    localparam logic [data_width-1:0] def_mem_fill_key = 32'h5a5a_0000;

    // engine states
    typedef enum logic [3:0] {
        idle,
        init,
        request_bus,
        set_up,
        read,
        wait_end,
        write,
        end_error,
        end_write
    } dma_state_t;

    // address view of the multiplexed word
    typedef struct packed {
        logic [addr_width-3:0] word_index;
        logic [1:0]            byte_offset;
    } bus_addr_t;

    // one bus word, decoded as address on begin and as data on beats
    typedef union packed {
        bus_addr_t              addr;
        logic [data_width-1:0]  data;
    } bus_word_t;

endpackage

`default_nettype wire

//--- dma_subsystem.sv
`default_nettype none

module dma_subsystem
    import dma_pkg::*;
    #(
    parameter logic [addr_width-1:0] base_address = 32'h0,
    parameter int unsigned           mem_words    = def_mem_words,
    parameter logic [data_width-1:0] mem_fill_key = def_mem_fill_key
    ) (
    input  logic                      clock,
    input  logic                      n_reset,
    input  logic                      launch_write,
    input  logic                      launch_read,
    input  logic [3:0]                byte_enable,
    input  logic [addr_width-1:0]     address,
    input  logic [burst_width-1:0]    burst_size,
    input  logic [burst_width-1:0]    block_size,
    output logic                      dma_busy,
    output logic                      dma_error,
    input  logic [buf_addr_width-1:0] ip_address,
    input  logic [data_width-1:0]     ip_write_data,
    input  logic                      ip_write_enable,
    output logic [data_width-1:0]     ip_read_data,
    input  logic                      other_request,
    output logic                      other_grant,
    input  logic                      mem_stall
    );

    dma_bus_if bus ();

    logic [buf_addr_width-1:0] buf_address;
    logic [data_width-1:0]     buf_write_data;
    logic                      buf_write_enable;
    logic [data_width-1:0]     buf_read_data;
    logic                      request;
    logic                      grant;

    // direction of the running transaction
    logic dir_read;
    logic target_drives;

    always_ff @(posedge clock) begin
        if (!n_reset) begin
            dir_read <= 1'b0;
        end else if (bus.begin_transaction) begin
            dir_read <= bus.read_n_write;
        end
    end

    // address phase always from the master
    assign target_drives = dir_read && !bus.begin_transaction;

    assign bus.address_data    = target_drives ? bus.tgt_address_data : bus.mst_address_data;
    assign bus.data_valid      = target_drives ? bus.tgt_data_valid : bus.mst_data_valid;
    assign bus.end_transaction = target_drives ? bus.tgt_end_transaction
                                               : bus.mst_end_transaction;

    dma_engine #(
        .base_address(base_address)
    ) u_engine (
        .clock           (clock),
        .n_reset         (n_reset),
        .launch_write    (launch_write),
        .launch_read     (launch_read),
        .byte_enable     (byte_enable),
        .address         (address),
        .burst_size      (burst_size),
        .block_size      (block_size),
        .dma_busy        (dma_busy),
        .dma_error       (dma_error),
        .buf_address     (buf_address),
        .buf_write_data  (buf_write_data),
        .buf_write_enable(buf_write_enable),
        .buf_read_data   (buf_read_data),
        .bus             (bus.master),
        .request         (request),
        .grant           (grant)
    );

    transfer_buffer #(
        .depth(2 ** buf_addr_width)
    ) u_buffer (
        .clock           (clock),
        .ip_address      (ip_address),
        .ip_write_data   (ip_write_data),
        .ip_write_enable (ip_write_enable),
        .ip_read_data    (ip_read_data),
        .dma_address     (buf_address),
        .dma_write_data  (buf_write_data),
        .dma_write_enable(buf_write_enable),
        .dma_read_data   (buf_read_data)
    );

    bus_arbiter u_arbiter (
        .clock        (clock),
        .n_reset      (n_reset),
        .request      (request),
        .other_request(other_request),
        .grant        (grant),
        .other_grant  (other_grant)
    );

    bus_memory #(
        .mem_words   (mem_words),
        .mem_fill_key(mem_fill_key)
    ) u_memory (
        .clock  (clock),
        .n_reset(n_reset),
        .bus    (bus.target),
        .stall  (mem_stall)
    );

endmodule

`default_nettype wire

//--- dma_sva.sv
`default_nettype none

module dma_sva
    import dma_pkg::*;
    (
    input logic       clock,
    input logic       n_reset,
    input dma_state_t state,
    input logic       launch_write,
    input logic       launch_read,
    input logic       begin_transaction,
    input logic       data_valid,
    input logic       request,
    input logic       dma_busy
    );

    timeunit 1ns;
    timeprecision 1ps;

    // begin is a one-cycle pulse
    begin_pulse: assert property (@(posedge clock) disable iff (!n_reset)
        begin_transaction |=> !begin_transaction)
        else $error("begin_transaction held for more than one cycle");

    // no beat while still asking for the bus
    beat_vs_request: assert property (@(posedge clock) disable iff (!n_reset)
        !(data_valid && request))
        else $error("data_valid and request high together");

    // idle stays not busy until a launch
    idle_not_busy: assert property (@(posedge clock) disable iff (!n_reset)
        (state == idle) |=> (dma_busy == $past(launch_write || launch_read)))
        else $error("dma_busy wrong after idle");

endmodule

bind dma_engine dma_sva u_sva (
    .clock            (clock),
    .n_reset          (n_reset),
    .state            (state),
    .launch_write     (launch_write),
    .launch_read      (launch_read),
    .begin_transaction(bus.begin_transaction),
    .data_valid       (bus.data_valid),
    .request          (request),
    .dma_busy         (dma_busy)
);

`default_nettype wire

//--- dma_tb.sv
`default_nettype none

module dma_tb
    import dma_pkg::*;
    ();

    timeunit 1ns;
    timeprecision 1ps;

    // own copy of the memory setup
    localparam int unsigned mem_words  = 1024;
    localparam logic [31:0] fill_key   = 32'h5a5a_0000;
    localparam int          n_rows     = 12;
    localparam int          wait_limit = 4000;

    typedef struct packed {
        logic        is_write;
        logic [31:0] address;
        logic [7:0]  burst;
        logic [7:0]  block;
        logic        stall;
        logic        contend;
        logic        bad;
    } row_t;

    logic        clock;
    logic        n_reset;
    logic        launch_write    = 1'b0;
    logic        launch_read     = 1'b0;
    logic [3:0]  byte_enable     = 4'h0;
    logic [31:0] address         = 32'h0;
    logic [7:0]  burst_size      = 8'h0;
    logic [7:0]  block_size      = 8'h0;
    logic        dma_busy;
    logic        dma_error;
    logic [8:0]  ip_address      = 9'h0;
    logic [31:0] ip_write_data   = 32'h0;
    logic        ip_write_enable = 1'b0;
    logic [31:0] ip_read_data;
    logic        other_request   = 1'b0;
    logic        other_grant;
    logic        mem_stall       = 1'b0;

    row_t        rows [n_rows];
    string       names [n_rows];
    // expected memory contents, updated by each write
    logic [31:0] model [mem_words];
    logic [31:0] fill_words [256];
    int          seed;
    logic        stall_on   = 1'b0;
    logic        contend_on = 1'b0;
    logic        aborted;

    tb_clock_gen #(.half_period(10), .reset_cycles(4)) u_clock (
        .clock  (clock),
        .n_reset(n_reset)
    );

    dma_subsystem #(
        .base_address(32'h0),
        .mem_words   (mem_words),
        .mem_fill_key(fill_key)
    ) DUT (
        .clock(clock), .n_reset(n_reset),
        .launch_write(launch_write), .launch_read(launch_read),
        .byte_enable(byte_enable), .address(address),
        .burst_size(burst_size), .block_size(block_size),
        .dma_busy(dma_busy), .dma_error(dma_error),
        .ip_address(ip_address), .ip_write_data(ip_write_data),
        .ip_write_enable(ip_write_enable), .ip_read_data(ip_read_data),
        .other_request(other_request), .other_grant(other_grant),
        .mem_stall(mem_stall)
    );

    dma_checker u_checker (
        .clock(clock), .n_reset(n_reset),
        .dma_busy(dma_busy), .dma_error(dma_error),
        .grant(DUT.grant), .other_grant(other_grant),
        .ip_read_data(ip_read_data)
    );

    // random back-pressure and second master, only when the row asks
    always @(posedge clock) begin
        int r;
        r = $random(seed);
        mem_stall     <= stall_on & r[0];
        other_request <= contend_on & r[1];
    end

    task automatic set_row(input int i, input string name, input logic w,
                           input int word, input int burst, input int block,
                           input logic s, input logic c, input logic b);
        names[i] = name;
        rows[i]  = {w, 32'(word * 4), 8'(burst), 8'(block), s, c, b};
    endtask

    task automatic build_table();
        //       name              wr  word  burst blk  stall cont  bad
        set_row(0,  "read_b4_n16",   0, 0,    4, 16, 0, 0, 0);
        set_row(1,  "read_b3_n10",   0, 100,  3, 10, 0, 0, 0);
        set_row(2,  "read_b8_n5",    0, 300,  8, 5,  0, 0, 0);
        set_row(3,  "read_b1_n4",    0, 1020, 1, 4,  0, 0, 0);
        set_row(4,  "write_b4_n12",  1, 200,  4, 12, 0, 0, 0);
        set_row(5,  "write_b5_n13",  1, 512,  5, 13, 0, 0, 0);
        set_row(6,  "read_stall",    0, 40,   4, 9,  1, 0, 0);
        set_row(7,  "write_stall",   1, 600,  3, 11, 1, 0, 0);
        set_row(8,  "read_contend",  0, 700,  4, 16, 0, 1, 0);
        set_row(9,  "write_contend", 1, 800,  6, 20, 1, 1, 0);
        set_row(10, "bus_error",     0, 1024, 4, 8,  0, 0, 1);
        set_row(11, "after_error",   0, 202,  4, 8,  0, 0, 0);
    endtask

    // fill with random words, or clear to zero
    task automatic write_buffer(input int count, input logic random_words);
        for (int i = 0; i < count; i++) begin
            @(posedge clock);
            if (random_words) begin
                fill_words[i] = $random(seed);
            end
            ip_address      <= 9'(i);
            ip_write_data   <= random_words ? fill_words[i] : 32'h0;
            ip_write_enable <= 1'b1;
        end
        @(posedge clock);
        ip_write_enable <= 1'b0;
    endtask

    task automatic launch(input row_t row, input logic do_read);
        @(posedge clock);
        address      <= row.address;
        burst_size   <= row.burst;
        block_size   <= row.block;
        byte_enable  <= 4'hf;
        launch_write <= !do_read;
        launch_read  <= do_read;
        @(posedge clock);
        launch_write <= 1'b0;
        launch_read  <= 1'b0;
    endtask

    // busy must rise, then fall within the limit
    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        @(negedge clock);
        if (!dma_busy) begin
            u_checker.report_problem($sformatf("%s: dma_busy did not rise after launch", name));
        end
        while (dma_busy && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        if (dma_busy) begin
            u_checker.report_problem($sformatf("%s: transfer still busy after %0d cycles",
                                               name, wait_limit));
            aborted = 1'b1;
        end
    endtask

    // registered ip read, sampled on the falling edge
    task automatic check_buffer(input string name, input int first, input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clock);
            ip_address <= 9'(i);
            @(posedge clock);
            @(negedge clock);
            u_checker.compare_word(name, i, model[first + i]);
        end
    endtask

    task automatic run_row(input int r);
        row_t row;
        int   first;
        row   = rows[r];
        first = int'(row.address[31:2]);
        stall_on   <= row.stall;
        contend_on <= row.contend;
        if (row.is_write) begin
            write_buffer(int'(row.block), 1'b1);
            launch(row, 1'b0);
            wait_done(names[r]);
            if (!aborted) begin
                u_checker.compare_flag(names[r], 1'b0);
                for (int i = 0; i < int'(row.block); i++) begin
                    model[first + i] = fill_words[i];
                end
            end
        end
        // every row ends with a read back into a cleared buffer
        if (!aborted) begin
            write_buffer(int'(row.block), 1'b0);
            launch(row, 1'b1);
            wait_done(names[r]);
        end
        if (!aborted) begin
            u_checker.compare_flag(names[r], row.bad);
            if (!row.bad) begin
                check_buffer(names[r], first, int'(row.block));
            end
        end
        stall_on   <= 1'b0;
        contend_on <= 1'b0;
    endtask

    initial begin
        int cycles;
        seed    = 32'hc21f_0939;
        aborted = 1'b0;
        cycles  = 0;
        for (int i = 0; i < int'(mem_words); i++) begin
            model[i] = 32'(i) ^ fill_key;
        end
        build_table();
        while (!n_reset && cycles < 50) begin
            @(posedge clock);
            cycles++;
        end
        if (!n_reset) begin
            u_checker.report_problem("reset never released");
            aborted = 1'b1;
        end
        for (int r = 0; r < n_rows && !aborted; r++) begin
            run_row(r);
        end
        $display("value errors %0d, other errors %0d",
                 u_checker.value_errors, u_checker.other_errors);
        if (u_checker.value_errors == 0 && u_checker.other_errors == 0 && !aborted) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
dma_pkg.sv
dma_bus_if.sv
dma_engine.sv
transfer_buffer.sv
bus_arbiter.sv
bus_memory.sv
dma_subsystem.sv
tb_clock_gen.sv
dma_checker.sv
dma_sva.sv
dma_tb.sv

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 4
    ) (
    output logic clock,
    output logic n_reset
    );

    timeunit 1ns;
    timeprecision 1ps;

    // free running clock, 20 ns period
    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    // reset low for the first few edges
    initial begin
        n_reset = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        n_reset <= 1'b1;
    end

endmodule

`default_nettype wire

//--- transfer_buffer.sv
`default_nettype none

module transfer_buffer
    import dma_pkg::*;
    #(
    parameter int depth = 512
    ) (
    input  logic                      clock,
    input  logic [buf_addr_width-1:0] ip_address,
    input  logic [data_width-1:0]     ip_write_data,
    input  logic                      ip_write_enable,
    output logic [data_width-1:0]     ip_read_data,
    input  logic [buf_addr_width-1:0] dma_address,
    input  logic [data_width-1:0]     dma_write_data,
    input  logic                      dma_write_enable,
    output logic [data_width-1:0]     dma_read_data
    );

    logic [data_width-1:0] mem [depth];

    always_ff @(posedge clock) begin
        if (ip_write_enable) begin
            mem[ip_address] <= ip_write_data;
        end
        // later write wins on a shared address
        if (dma_write_enable) begin
            mem[dma_address] <= dma_write_data;
        end
        // registered reads on both ports
        ip_read_data  <= mem[ip_address];
        dma_read_data <= mem[dma_address];
    end

endmodule

`default_nettype wire
